//--- dv/noc_traffic_patterns.txt
// Columns, all hex: mode rate enable_cycles ack_rise_delay ack_fall_delay flags
// Mode 0 uniform, 1 hotspot, 2 stream; flags bit0 ack jitter, bit1 no drops allowed
// Uniform, low rate, fast ack
0 04000000 12C 0 0 2
// Hotspot, low rate, fast ack
1 04000000 190 0 0 2
// Stream, low rate, stream source at twice the rate
2 03000000 190 0 0 2
// Uniform, high rate, slow jittered ack, drops expected
0 80000000 12C 3 2 1
// Hotspot, medium rate, short jittered ack
1 20000000 100 1 1 1
// Stream, stream threshold saturates, slow jittered ack
2 90000000 12C 4 3 1
// Uniform, very low rate, fixed slow ack
0 02000000 190 2 2 0

//--- noc_traffic_gen.f
verilog/noc_cfg_pkg.sv
verilog/noc_pkt_pkg.sv
verilog/pkt_queue_if.sv
verilog/packet_fifo.sv
verilog/packet_source.sv
verilog/link_scheduler.sv
verilog/noc_traffic_gen.sv
dv/noc_traffic_checker.sv
dv/noc_traffic_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the traffic generator testbench with Verilator
# Paths are relative to the project root
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module noc_traffic_gen_tb \
  -f noc_traffic_gen.f \
  -o Vnoc_traffic_gen_tb

# Result is taken from the log
./obj_dir/Vnoc_traffic_gen_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
  echo "Simulation ended without a result, see $LOG"
  exit 1
fi
echo "Simulation passed"

//--- dv/noc_traffic_gen_tb.sv
//####################
// Top testbench for the traffic generator
// Tests are read from dv/noc_traffic_patterns.txt, run from the project root
// At most 16 tests, ack jitter only on tests flagged for it
//####################

`timescale 1ns/1ps

module noc_traffic_gen_tb import noc_cfg_pkg::*; import noc_pkt_pkg::*; ();

  localparam int MAX_TESTS    = 16;
  localparam int WORDS        = 6;   // Words per test line
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 5;   // Enable low after reset, no request allowed
  localparam int QUIET_CYCLES = 8;   // Req and ack low this long means drained

  logic          clk;
  logic          reset_n;
  logic          enable;
  traffic_mode_e mode;
  rate_t         rate;
  logic          ack;
  logic          req;
  port_id_t      dest;
  port_id_t      source;
  stamp_t        stamp;
  drop_cnt_t     drop_count;
  logic          lossless;           // Current test must not drop
  logic          test_done;          // One-cycle pulse to the checker
  logic [31:0]   pat_mem [MAX_TESTS*WORDS];
  int            num_tests;
  int            rise_delay;
  int            fall_delay;
  logic          jitter_on;
  logic [31:0]   lcg_state;
  longint        cycle_limit = 0;
  longint        cycles = 0;
  int            errors;
  int            checks;

  // 100 ns period
  always
  begin
    clk = 1'b0;
    #50;
    clk = 1'b1;
    #50;
  end

  noc_traffic_gen uut (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_enable     (enable),
    .i_mode       (mode),
    .i_rate       (rate),
    .i_ack        (ack),
    .o_req        (req),
    .o_dest       (dest),
    .o_source     (source),
    .o_stamp      (stamp),
    .o_drop_count (drop_count)
  );

  noc_traffic_checker u_checker (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_enable     (enable),
    .i_mode       (mode),
    .i_rate       (rate),
    .i_ack        (ack),
    .i_req        (req),
    .i_dest       (dest),
    .i_source     (source),
    .i_stamp      (stamp),
    .i_drop_count (drop_count),
    .i_lossless   (lossless),
    .i_test_done  (test_done),
    .o_errors     (errors),
    .o_checks     (checks)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // 0 to 2 extra cycles on jittered tests
  task automatic add_jitter(inout int delay);
    if (jitter_on)
    begin
      lcg_state = lcg_next(lcg_state);
      delay = delay + int'(lcg_state[17:16]) % 3;
    end
  endtask

  // Four-phase sink, all changes on the falling edge
  initial
  begin : ack_responder
    int delay;
    ack = 1'b0;
    forever
    begin
      @(negedge clk);
      if (req)
      begin
        delay = rise_delay;
        add_jitter(delay);
        repeat (delay) @(negedge clk);
        ack = 1'b1;
        while (req) @(negedge clk);  // Hold until request drops
        delay = fall_delay;
        add_jitter(delay);
        repeat (delay) @(negedge clk);
        ack = 1'b0;
      end
    end
  end

  task automatic load_patterns();
    longint rt;
    int     base;
    for (int i = 0; i < MAX_TESTS * WORDS; i++)
      pat_mem[i] = '0;
    $readmemh("dv/noc_traffic_patterns.txt", pat_mem);
    num_tests = 0;
    while (num_tests < MAX_TESTS && pat_mem[num_tests * WORDS + 2] != 0)
    begin
      base = num_tests * WORDS;
      rt = pat_mem[base + 3] + pat_mem[base + 4] + 4 + (pat_mem[base + 5][0] ? 4 : 0);
      // Enable window, fixed overhead, then every queue slot drained at worst speed
      cycle_limit += pat_mem[base + 2] + RESET_CYCLES + IDLE_CYCLES + QUIET_CYCLES + 4;
      cycle_limit += FIFO_DEPTH * NUM_PORTS * rt;
      num_tests++;
    end
    cycle_limit = 2 * cycle_limit + 20;
    if (num_tests == 0)
      $display("Failure: no tests found in the pattern file");
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset_n = 1'b1;                  // Active high
    repeat (RESET_CYCLES) @(negedge clk);
    reset_n = 1'b0;
  endtask

  task automatic wait_link_idle();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES)
    begin
      @(negedge clk);
      if (!req && !ack)
        quiet++;
      else
        quiet = 0;
    end
  endtask

  task automatic run_test(input int t);
    int base;
    base = t * WORDS;
    apply_reset();
    mode       = traffic_mode_e'(pat_mem[base][1:0]);
    rate       = pat_mem[base + 1];
    rise_delay = int'(pat_mem[base + 3]);
    fall_delay = int'(pat_mem[base + 4]);
    jitter_on  = pat_mem[base + 5][0];
    lossless   = pat_mem[base + 5][1];
    repeat (IDLE_CYCLES) @(negedge clk);
    enable = 1'b1;
    repeat (pat_mem[base + 2]) @(negedge clk);
    enable = 1'b0;
    wait_link_idle();
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial
  begin : stimulus
    reset_n    = 1'b1;
    enable     = 1'b0;
    mode       = UNIFORM;
    rate       = '0;
    lossless   = 1'b0;
    test_done  = 1'b0;
    rise_delay = 0;
    fall_delay = 0;
    jitter_on  = 1'b0;
    lcg_state  = 32'd17;             // LCG seed
    load_patterns();
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    @(negedge clk);
    $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0 && num_tests > 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Cycle limit from the test lengths
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("Timeout: run still going after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

endmodule : noc_traffic_gen_tb

//--- dv/noc_traffic_checker.sv
//####################
// Link scoreboard with its own LFSR model per port
// Inputs are sampled on the rising edge
// Drops are checked as a per-test total when i_test_done pulses
// Each port holds at most 2048 candidates per test
//####################

`timescale 1ns/1ps

module noc_traffic_checker import noc_cfg_pkg::*; import noc_pkt_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          i_enable,
  input  traffic_mode_e i_mode,
  input  rate_t         i_rate,
  input  logic          i_ack,
  input  logic          i_req,
  input  port_id_t      i_dest,
  input  port_id_t      i_source,
  input  stamp_t        i_stamp,
  input  drop_cnt_t     i_drop_count,
  input  logic          i_lossless,   // No drops allowed in this test
  input  logic          i_test_done,  // Link drained, close the test
  output int            o_errors,
  output int            o_checks
);

  localparam int EXP_SIZE = 2048;

  lfsr_t    lfsr_m [NUM_PORTS];       // Model LFSR per port
  stamp_t   stamp_m;                  // Model timestamp
  port_id_t exp_dest  [NUM_PORTS][EXP_SIZE];
  stamp_t   exp_stamp [NUM_PORTS][EXP_SIZE];
  int       head [NUM_PORTS];         // Next candidate the link should send
  int       tail [NUM_PORTS];
  int       skipped;                  // Candidates passed over as drops
  int       received;
  int       test_no = 0;
  int       errors = 0;
  int       checks = 0;
  logic     req_q = 1'b0;
  logic     ack_q = 1'b0;             // Ack at the previous edge
  logic     rst_q = 1'b1;
  port_id_t dest_q;
  port_id_t source_q;
  stamp_t   stamp_q;

  assign o_errors = errors;
  assign o_checks = checks;

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic flag_failure(input string msg);
    errors++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  function automatic lfsr_t lfsr_step(input lfsr_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 31, 21, 1, 0
  endfunction

  // Returns {candidate, dest}
  function automatic logic [2:0] predict_candidate(input int port, input traffic_mode_e mode,
      input rate_t rate, input lfsr_t lfsr, input stamp_t stamp);
    int          raw;
    logic [63:0] thr;
    logic        warm;
    logic        hit;
    raw  = int'(lfsr[9:8]) % 3;
    if (raw >= port)
      raw++;                          // Skip own port
    warm = (stamp >= stamp_t'(WARMUP_CYCLES));
    hit  = (lfsr < rate);
    case (mode)
      UNIFORM: ;
      HOTSPOT:
      begin
        hit = hit && warm;
        if (lfsr[5:3] == 3'd1 || lfsr[5:3] == 3'd4)
          raw = (port == HOTSPOT_PORT_A) ? HOTSPOT_PORT_B : HOTSPOT_PORT_A;
      end
      STREAM:
      begin
        if (port == STREAM_SRC)
        begin
          thr = 64'(rate) << STREAM_RATE_SHIFT;
          if (thr > 64'hFFFF_FFFF)
            thr = 64'hFFFF_FFFF;      // Saturated threshold
          hit = (64'(lfsr) < thr) && warm;
          raw = STREAM_DST;
        end
        else
          hit = hit && warm;
      end
      default: hit = 1'b0;
    endcase
    return {hit, raw[1:0]};
  endfunction

  task automatic take_packet();
    int p;
    p = int'(i_source);
    received++;
    if (i_source == i_dest)
      flag_failure($sformatf("packet from port %0d addressed to itself", p));
    if (i_mode != UNIFORM && i_stamp < stamp_t'(WARMUP_CYCLES))
      flag_failure($sformatf("packet stamped %0d during warm-up", i_stamp));
    if (i_mode == STREAM && p == STREAM_SRC)
      compare_value("o_dest", 64'(i_dest), 64'(STREAM_DST));
    if (i_lossless && head[p] < tail[p])
      compare_value("o_stamp", 64'(i_stamp), 64'(exp_stamp[p][head[p]]));
    while (head[p] < tail[p] && exp_stamp[p][head[p]] < i_stamp)
    begin
      head[p]++;                      // Dropped at a full queue
      skipped++;
    end
    if (head[p] == tail[p] || exp_stamp[p][head[p]] != i_stamp)
      flag_failure($sformatf("packet from port %0d stamp %0d was never predicted", p, i_stamp));
    else
    begin
      compare_value("o_dest", 64'(i_dest), 64'(exp_dest[p][head[p]]));
      head[p]++;
    end
  endtask

  task automatic close_test();
    int     leftover;
    longint model_drops;
    leftover = 0;
    for (int p = 0; p < NUM_PORTS; p++)
      leftover += tail[p] - head[p];
    model_drops = skipped + leftover;
    if (model_drops > (2 ** DROP_W) - 1)
      model_drops = (2 ** DROP_W) - 1;
    test_no++;
    $display("Test %0d: %0d candidates, %0d received, %0d dropped", test_no,
             received + skipped + leftover, received, i_drop_count);
    if (received + skipped + leftover == 0)
      flag_failure("test produced no candidates");
    compare_value("o_drop_count", 64'(i_drop_count), 64'(model_drops));
    if (i_lossless)
      compare_value("o_drop_count", 64'(i_drop_count), 64'd0);
  endtask

  always @(posedge clk)
  begin : monitor
    logic [2:0] pred;
    if (reset_n)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        lfsr_m[p] = lfsr_t'(LFSR_SEED_BASE * lfsr_t'(p + 1));
        head[p]   = 0;
        tail[p]   = 0;
      end
      stamp_m  = '0;
      skipped  = 0;
      received = 0;
    end
    else
    begin
      if (rst_q)
      begin
        compare_value("o_req", 64'(i_req), 64'd0);            // Reset values
        compare_value("o_drop_count", 64'(i_drop_count), 64'd0);
      end
      // Candidates from the pre-advance LFSR and the current stamp
      if (i_enable)
        for (int p = 0; p < NUM_PORTS; p++)
        begin
          pred = predict_candidate(p, i_mode, i_rate, lfsr_m[p], stamp_m);
          if (pred[2] && tail[p] >= EXP_SIZE)
            flag_failure("expected packet buffer overflow");
          else if (pred[2])
          begin
            exp_dest[p][tail[p]]  = pred[1:0];
            exp_stamp[p][tail[p]] = stamp_m;
            tail[p]++;
          end
          lfsr_m[p] = lfsr_step(lfsr_m[p]);
        end
      stamp_m = stamp_m + 1'b1;
      if (i_req && !req_q)
      begin
        if (ack_q)
          flag_failure("o_req rose while i_ack was high");
        take_packet();
      end
      else if (i_req && req_q)
      begin
        compare_value("o_dest", 64'(i_dest), 64'(dest_q));    // Held while requesting
        compare_value("o_source", 64'(i_source), 64'(source_q));
        compare_value("o_stamp", 64'(i_stamp), 64'(stamp_q));
      end
      if (i_test_done)
        close_test();
    end
    rst_q    = reset_n;
    req_q    = i_req;
    ack_q    = i_ack;
    dest_q   = i_dest;
    source_q = i_source;
    stamp_q  = i_stamp;
  end

endmodule : noc_traffic_checker

//--- verilog/noc_traffic_gen.sv
//####################
// Traffic generator top, four sources and one output link
// Timestamp runs from reset regardless of i_enable
// Drop count saturates at all ones
//####################

`timescale 1ns/1ps

module noc_traffic_gen import noc_cfg_pkg::*; import noc_pkt_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          i_enable,
  input  traffic_mode_e i_mode,
  input  rate_t         i_rate,
  input  logic          i_ack,
  output logic          o_req,
  output port_id_t      o_dest,
  output port_id_t      o_source,
  output stamp_t        o_stamp,
  output drop_cnt_t     o_drop_count
);

  stamp_t                 timestamp;
  logic   [NUM_PORTS-1:0] src_drop;   // Per-source drop pulses
  drop_cnt_t              drop_sum;   // Drops in this cycle
  logic   [DROP_W:0]      drop_next;  // Carry bit flags saturation

  pkt_queue_if q_if [NUM_PORTS] ();

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
      timestamp <= '0;
    else
      timestamp <= timestamp + 1'b1;
  end

  // Several sources can drop in the same cycle
  always_comb
  begin
    drop_sum = '0;
    for (int p = 0; p < NUM_PORTS; p++)
      drop_sum = drop_sum + drop_cnt_t'(src_drop[p]);
    drop_next = {1'b0, o_drop_count} + {1'b0, drop_sum};
  end

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
      o_drop_count <= '0;
    else if (drop_next[DROP_W])
      o_drop_count <= '1;                   // Saturate
    else
      o_drop_count <= drop_next[DROP_W-1:0];
  end

  for (genvar g = 0; g < NUM_PORTS; g++)
  begin : g_src
    packet_source #(
      .PORT_NO (g)
    ) u_src (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_enable    (i_enable),
      .i_mode      (i_mode),
      .i_rate      (i_rate),
      .i_timestamp (timestamp),
      .o_drop      (src_drop[g]),
      .q           (q_if[g])
    );
  end

  link_scheduler u_sched (
    .clk      (clk),
    .reset_n  (reset_n),
    .q        (q_if),
    .o_req    (o_req),
    .i_ack    (i_ack),
    .o_dest   (o_dest),
    .o_source (o_source),
    .o_stamp  (o_stamp)
  );

endmodule : noc_traffic_gen

//--- verilog/link_scheduler.sv
//####################
// Round-robin drain of the source queues onto one four-phase link
// A new request only starts once ack has returned low
//####################

`timescale 1ns/1ps

module link_scheduler import noc_cfg_pkg::*; import noc_pkt_pkg::*; (
  input  logic           clk,
  input  logic           reset_n,
  pkt_queue_if.scheduler q [NUM_PORTS],
  output logic           o_req,
  input  logic           i_ack,
  output port_id_t       o_dest,
  output port_id_t       o_source,
  output stamp_t         o_stamp
);

  link_state_e state;
  port_id_t    last_port;  // Last port served
  port_id_t    sel;        // Next port to serve
  logic        found;

  logic     [NUM_PORTS-1:0] valid_v;
  logic     [NUM_PORTS-1:0] pop_v;
  port_id_t                 dest_v  [NUM_PORTS];
  stamp_t                   stamp_v [NUM_PORTS];

  // Flatten the interface array for variable indexing
  for (genvar g = 0; g < NUM_PORTS; g++)
  begin : g_port
    assign valid_v[g] = q[g].valid;
    assign dest_v[g]  = q[g].dest;
    assign stamp_v[g] = q[g].stamp;
    assign q[g].pop   = pop_v[g];
  end

  // Search starts just after the last served port
  always_comb
  begin
    found = 1'b0;
    sel   = last_port;
    for (int i = 1; i <= NUM_PORTS; i++)
    begin
      port_id_t idx;
      idx = port_id_t'((int'(last_port) + i) % NUM_PORTS);
      if (!found && valid_v[idx])
      begin
        found = 1'b1;
        sel   = idx;
      end
    end
  end

  // Pop in the same edge that raises the request
  always_comb
  begin
    pop_v = '0;
    if (state == IDLE && found)
      pop_v[sel] = 1'b1;
  end

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      state     <= IDLE;
      last_port <= port_id_t'(NUM_PORTS - 1);  // Port 0 goes first
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (found)
          begin
            state     <= REQ_HIGH;
            last_port <= sel;
          end
        end
        REQ_HIGH:
        begin
          if (i_ack)
            state <= WAIT_ACK_LOW;  // Sink took the fields
        end
        WAIT_ACK_LOW:
        begin
          if (!i_ack)
            state <= IDLE;          // Handshake closed
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Link fields load only on a pop
  always_ff @(posedge clk)
  begin
    if (state == IDLE && found)
    begin
      o_dest   <= dest_v[sel];
      o_source <= sel;
      o_stamp  <= stamp_v[sel];
    end
  end

  assign o_req = (state == REQ_HIGH);

  a_fields_stable: assert property (@(posedge clk) disable iff (reset_n)
    o_req |=> !o_req || $stable({o_dest, o_source, o_stamp}));
  // A pop starts a transfer and lasts one cycle
  a_one_pop: assert property (@(posedge clk) disable iff (reset_n)
    (pop_v != '0) |=> (pop_v == '0));

endmodule : link_scheduler

//--- verilog/packet_source.sv
//####################
// LFSR traffic source for one port
// Candidates follow the LFSR only, never the queue state
// A candidate hitting a full queue is dropped and flagged on o_drop
//####################

`timescale 1ns/1ps

module packet_source import noc_cfg_pkg::*; import noc_pkt_pkg::*; #(
  parameter int PORT_NO = 0  // Own port, never used as destination
) (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          i_enable,     // Advance LFSR and generate
  input  traffic_mode_e i_mode,
  input  rate_t         i_rate,       // Candidate when LFSR below this
  input  stamp_t        i_timestamp,
  output logic          o_drop,       // One-cycle pulse per suppressed candidate
  pkt_queue_if.source   q
);

  lfsr_t    lfsr;
  port_id_t raw_dest;     // LFSR bits 9:8 modulo 3
  port_id_t uni_dest;     // Raw destination skipping own port
  port_id_t hot_dest;
  logic     warm;         // Past warm-up
  logic     below_rate;
  logic     below_stream;
  logic [31+STREAM_RATE_SHIFT:0] stream_wide;
  rate_t    stream_rate;  // Saturated stream threshold
  logic     cand;
  port_id_t cand_dest;
  logic     wr;
  logic     fifo_empty;
  logic     fifo_full;

  // Fibonacci LFSR, taps 31/21/1/0 shifted in at bit 0
  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
      lfsr <= lfsr_t'(LFSR_SEED_BASE * (PORT_NO + 1));
    else if (i_enable)
      lfsr <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
  end

  assign raw_dest = port_id_t'(lfsr[9:8] % 2'd3);
  assign uni_dest = (raw_dest >= PORT_NO) ? port_id_t'(raw_dest + 2'd1) : raw_dest;

  // Pattern 1 or 4 on bits 5:3 sends to the hotspot
  always_comb
  begin
    hot_dest = uni_dest;
    if (lfsr[5:3] == 3'd1 || lfsr[5:3] == 3'd4)
      hot_dest = (PORT_NO == HOTSPOT_PORT_A) ? port_id_t'(HOTSPOT_PORT_B)
                                             : port_id_t'(HOTSPOT_PORT_A);
  end

  assign warm        = (i_timestamp >= stamp_t'(WARMUP_CYCLES));
  assign below_rate  = (lfsr < i_rate);
  assign stream_wide = {i_rate, {STREAM_RATE_SHIFT{1'b0}}};
  assign stream_rate = (|stream_wide[31+STREAM_RATE_SHIFT:32]) ? '1 : stream_wide[31:0];
  assign below_stream = (lfsr < stream_rate);

  // Candidate decision from the pre-advance LFSR
  always_comb
  begin
    cand      = 1'b0;
    cand_dest = uni_dest;
    case (i_mode)
      UNIFORM:
      begin
        cand = below_rate;
      end
      HOTSPOT:
      begin
        cand      = below_rate && warm;
        cand_dest = hot_dest;
      end
      STREAM:
      begin
        if (PORT_NO == STREAM_SRC)
        begin
          cand      = below_stream && warm;  // Heavier stream source
          cand_dest = port_id_t'(STREAM_DST);
        end
        else
        begin
          cand = below_rate && warm;         // Uniform background
        end
      end
      default:
      begin
        cand = 1'b0;                         // Unused encoding
      end
    endcase
  end

  assign wr = i_enable && cand && !fifo_full;

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
      o_drop <= 1'b0;
    else
      o_drop <= i_enable && cand && fifo_full;  // Counted at top
  end

  packet_fifo u_fifo (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_wr       (wr),
    .i_wr_dest  (cand_dest),
    .i_wr_stamp (i_timestamp),
    .i_rd       (q.pop),
    .o_dest     (q.dest),
    .o_stamp    (q.stamp),
    .o_empty    (fifo_empty),
    .o_full     (fifo_full)
  );

  assign q.valid = !fifo_empty;

  // Self-targeting must be impossible in every mode
  a_not_self: assert property (@(posedge clk) disable iff (reset_n)
    wr |-> cand_dest != port_id_t'(PORT_NO));

endmodule : packet_source

//--- verilog/packet_fifo.sv
//####################
// First-word-fall-through queue of destination and timestamp
// A written entry is visible on the cycle after the write
// Writing when full or reading when empty is not allowed
//####################

`timescale 1ns/1ps

module packet_fifo import noc_cfg_pkg::*; import noc_pkt_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     i_wr,        // Push one entry
  input  port_id_t i_wr_dest,
  input  stamp_t   i_wr_stamp,
  input  logic     i_rd,        // Pop the head
  output port_id_t o_dest,      // Head destination
  output stamp_t   o_stamp,     // Head timestamp
  output logic     o_empty,
  output logic     o_full
);

  // Entry storage
  port_id_t dest_mem  [FIFO_DEPTH];
  stamp_t   stamp_mem [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;

  // Wrap explicitly so a non power of two depth also works
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (i_wr)
    begin
      dest_mem[wr_ptr]  <= i_wr_dest;
      stamp_mem[wr_ptr] <= i_wr_stamp;
    end
  end

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_wr)
        wr_ptr <= ptr_inc(wr_ptr);
      if (i_rd)
        rd_ptr <= ptr_inc(rd_ptr);
      // Simultaneous push and pop leaves the count alone
      case ({i_wr, i_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign o_dest  = dest_mem[rd_ptr];   // Head falls through
  assign o_stamp = stamp_mem[rd_ptr];
  assign o_empty = (count == '0);
  assign o_full  = (count == FIFO_CNT_W'(FIFO_DEPTH));

  // Source suppresses writes on full and the scheduler pops only a valid head
  a_no_wr_full: assert property (@(posedge clk) disable iff (reset_n) i_wr |-> !o_full);
  a_no_rd_empty: assert property (@(posedge clk) disable iff (reset_n) i_rd |-> !o_empty);

endmodule : packet_fifo

//--- verilog/pkt_queue_if.sv
//####################
// Queue head of one source as seen by the scheduler
// Pop is only legal on a valid head and lasts one cycle
//####################

`timescale 1ns/1ps

interface pkt_queue_if import noc_pkt_pkg::*; ();

  logic     valid;  // FIFO head present
  port_id_t dest;   // Head destination
  stamp_t   stamp;  // Head generation timestamp
  logic     pop;    // Remove the head at the next edge

  // Source owns the queue
  modport source (
    output valid,
    output dest,
    output stamp,
    input  pop
  );

  // Scheduler consumes the head
  modport scheduler (
    input  valid,
    input  dest,
    input  stamp,
    output pop
  );

endinterface : pkt_queue_if

//--- verilog/noc_pkt_pkg.sv
//####################
// Packet field and state types
// Mode value 2'b11 is unused and generates nothing
//####################

package noc_pkt_pkg;
  import noc_cfg_pkg::*;

  typedef logic [1:0]        port_id_t;   // Source or destination port
  typedef logic [31:0]       stamp_t;     // Free-running cycle timestamp
  typedef logic [31:0]       rate_t;      // Generation threshold against the LFSR
  typedef logic [31:0]       lfsr_t;      // LFSR state word
  typedef logic [DROP_W-1:0] drop_cnt_t;  // Suppressed candidate count

  // Traffic pattern selection
  typedef enum logic [1:0] {
    UNIFORM = 2'd0,  // Any port except self
    HOTSPOT = 2'd1,  // Part of the traffic to the hotspot ports
    STREAM  = 2'd2   // Dedicated stream pair plus uniform background
  } traffic_mode_e;

  // Four-phase output link states
  typedef enum logic [1:0] {
    IDLE         = 2'd0,  // Waiting for a valid queue head
    REQ_HIGH     = 2'd1,  // Request up, fields held
    WAIT_ACK_LOW = 2'd2   // Request down, waiting for ack release
  } link_state_e;

endpackage : noc_pkt_pkg

//--- verilog/noc_cfg_pkg.sv
//####################
// Build-time configuration of the traffic generator
// Port ids are 2 bits wide, so NUM_PORTS must stay at 4
// Seeds must be nonzero after the per-port multiply
//####################

package noc_cfg_pkg;

  localparam int NUM_PORTS = 4;          // Packet sources, one per network port
  localparam int FIFO_DEPTH = 8;         // Entries per source queue

  // Derived queue widths
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Port p starts from LFSR_SEED_BASE * (p+1), truncated to 32 bits
  // An odd base keeps every per-port seed nonzero
  localparam logic [31:0] LFSR_SEED_BASE = 32'h2545_F491;

  // Hotspot targets, the second one is used by the first hotspot port itself
  localparam int HOTSPOT_PORT_A = 2;
  localparam int HOTSPOT_PORT_B = 3;

  localparam int STREAM_SRC = 0;         // Stream source port
  localparam int STREAM_DST = 3;         // Stream sink port
  localparam int STREAM_RATE_SHIFT = 1;  // Stream threshold = rate << shift, saturating

  // No hotspot or stream packets while the timestamp is below this
  localparam int WARMUP_CYCLES = 20;

  localparam int DROP_W = 16;            // Width of the saturating drop counter

endpackage : noc_cfg_pkg
